// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rv_core
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: src/decode_stage.sv
/* decode stage */
`timescale 1ns/1ns
`default_nettype none

`include "rv_macros.svh"

module decode_stage (
	input  logic              ip_clk,
	input  logic              ip_rst,
	input  logic              stall,
	input  logic              if_valid,
	input  logic              if_done,
	input  rv_pkg::instr_t    if_instr,
	input  rv_pkg::xlen_t     rs1_data,
	input  rv_pkg::xlen_t     rs2_data,
	output rv_pkg::reg_addr_t rs1_addr,
	output rv_pkg::reg_addr_t rs2_addr,
	output rv_pkg::reg_addr_t id_rs1_addr,
	output rv_pkg::reg_addr_t id_rs2_addr,
	output rv_pkg::reg_addr_t id_rd,
	output rv_pkg::xlen_t     id_a,
	output rv_pkg::xlen_t     id_b,
	output rv_pkg::xlen_t     id_imm,
	output rv_pkg::alu_op_e   id_alu_op,
	output logic              id_use_imm,
	output logic              id_reg_we,
	output logic              id_load,
	output logic              id_store,
	output logic              id_done
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	rv_pkg::xlen_t   imm_i, imm_s, imm_u, imm;
	rv_pkg::alu_op_e alu_op;
	logic            known, reg_we, use_imm, load, store;
	logic            live;

	assign opcode   = if_instr[6:0];
	assign funct3   = if_instr[14:12];
	assign rs1_addr = if_instr[19:15];
	assign rs2_addr = if_instr[24:20];

	assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_u = {if_instr[31:12], 12'b0};

	always_comb begin
		known   = 1'b1;
		reg_we  = 1'b0;
		use_imm = 1'b0;
		load    = 1'b0;
		store   = 1'b0;
		alu_op  = rv_pkg::ALU_ADD;
		imm     = imm_i;
		case (opcode)
			`OPC_OP, `OPC_OP_IMM: begin
				reg_we  = 1'b1;
				use_imm = (opcode == `OPC_OP_IMM);
				case (funct3)
					3'b000: begin
						// bit 30 picks sub, register form only
						if (!use_imm && if_instr[30]) alu_op = rv_pkg::ALU_SUB;
					end
					3'b010: begin
						alu_op = rv_pkg::ALU_SLT;
						known  = !use_imm;    // no slti
					end
					3'b100: alu_op = rv_pkg::ALU_XOR;
					3'b110: alu_op = rv_pkg::ALU_OR;
					3'b111: alu_op = rv_pkg::ALU_AND;
					default: known = 1'b0;
				endcase
			end
			`OPC_LUI: begin
				reg_we  = 1'b1;
				use_imm = 1'b1;
				imm     = imm_u;
				alu_op  = rv_pkg::ALU_PASS_B;
			end
			`OPC_LOAD: begin
				reg_we  = 1'b1;
				use_imm = 1'b1;
				load    = 1'b1;
				known   = (funct3 == 3'b010);   // lw only
			end
			`OPC_STORE: begin
				use_imm = 1'b1;
				store   = 1'b1;
				imm     = imm_s;
				known   = (funct3 == 3'b010);   // sw only
			end
			default: known = 1'b0;
		endcase
	end

	assign live = if_valid && known;   // unknown opcodes turn into bubbles

	always_ff @(posedge ip_clk or posedge ip_rst) begin
		if (ip_rst) begin
			id_reg_we <= 1'b0;
			id_load   <= 1'b0;
			id_store  <= 1'b0;
			id_done   <= 1'b0;
		end else if (!stall) begin
			id_reg_we <= live && reg_we;
			id_load   <= live && load;
			id_store  <= live && store;
			id_done   <= if_done;
		end
	end

	always_ff @(posedge ip_clk) begin
		if (!stall) begin
			id_rs1_addr <= rs1_addr;
			id_rs2_addr <= rs2_addr;
			id_rd       <= if_instr[11:7];
			id_a        <= rs1_data;
			id_b        <= rs2_data;
			id_imm      <= imm;
			id_alu_op   <= alu_op;
			id_use_imm  <= use_imm;
		end
	end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
/* execute stage */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input  logic              ip_clk,
	input  logic              ip_rst,
	input  logic              stall,
	input  rv_pkg::reg_addr_t id_rs1_addr,
	input  rv_pkg::reg_addr_t id_rs2_addr,
	input  rv_pkg::reg_addr_t id_rd,
	input  rv_pkg::xlen_t     id_a,
	input  rv_pkg::xlen_t     id_b,
	input  rv_pkg::xlen_t     id_imm,
	input  rv_pkg::alu_op_e   id_alu_op,
	input  logic              id_use_imm,
	input  logic              id_reg_we,
	input  logic              id_load,
	input  logic              id_store,
	input  logic              id_done,
	input  rv_pkg::reg_addr_t mem_rd,
	input  logic              mem_reg_we,
	input  rv_pkg::xlen_t     mem_fwd_data,
	input  rv_pkg::reg_addr_t wb_rd,
	input  logic              wb_we,
	input  rv_pkg::xlen_t     wb_data,
	output rv_pkg::xlen_t     ex_result,
	output rv_pkg::xlen_t     ex_store_data,
	output rv_pkg::reg_addr_t ex_rd,
	output logic              ex_reg_we,
	output logic              ex_load,
	output logic              ex_store,
	output logic              ex_done
);

	rv_pkg::xlen_t op_a, op_b, fwd_b, alu_y;

	// newest producer wins, x0 stays zero
	function automatic rv_pkg::xlen_t fwd(rv_pkg::reg_addr_t src, rv_pkg::xlen_t reg_val);
		if (src == '0) return reg_val;
		if (mem_reg_we && mem_rd == src) return mem_fwd_data;
		if (wb_we && wb_rd == src) return wb_data;
		return reg_val;
	endfunction

	always_comb begin
		op_a  = fwd(id_rs1_addr, id_a);
		fwd_b = fwd(id_rs2_addr, id_b);
		op_b  = id_use_imm ? id_imm : fwd_b;
		case (id_alu_op)
			rv_pkg::ALU_ADD:    alu_y = op_a + op_b;   // also load/store address
			rv_pkg::ALU_SUB:    alu_y = op_a - op_b;
			rv_pkg::ALU_AND:    alu_y = op_a & op_b;
			rv_pkg::ALU_OR:     alu_y = op_a | op_b;
			rv_pkg::ALU_XOR:    alu_y = op_a ^ op_b;
			rv_pkg::ALU_SLT:    alu_y = rv_pkg::xlen_t'($signed(op_a) < $signed(op_b));
			rv_pkg::ALU_PASS_B: alu_y = op_b;
			default:            alu_y = '0;
		endcase
	end

	always_ff @(posedge ip_clk or posedge ip_rst) begin
		if (ip_rst) begin
			ex_reg_we <= 1'b0;
			ex_load   <= 1'b0;
			ex_store  <= 1'b0;
			ex_done   <= 1'b0;
		end else if (!stall) begin
			ex_reg_we <= id_reg_we;
			ex_load   <= id_load;
			ex_store  <= id_store;
			ex_done   <= id_done;
		end
	end

	always_ff @(posedge ip_clk) begin
		if (!stall) begin
			ex_result     <= alu_y;
			ex_store_data <= fwd_b;   // store data also needs forwarding
			ex_rd         <= id_rd;
		end
	end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
/* instruction fetch */
`timescale 1ns/1ns
`default_nettype none

`include "rv_macros.svh"

module fetch_unit (
	input  logic             ip_clk,
	input  logic             ip_rst,
	input  logic             run,
	input  logic             stall,
	input  logic             fetch_gnt,
	input  rv_pkg::xlen_t    mem_rdata,
	output logic             fetch_req,
	output rv_pkg::mem_idx_t fetch_idx,
	output rv_pkg::instr_t   if_instr,
	output logic             if_valid,
	output logic             if_done
);

	rv_pkg::fetch_state_e state;
	rv_pkg::mem_idx_t     pc;
	logic                 halt_word;   // all-zero word ends the program
	logic                 take;        // granted fetch lands this cycle

	assign fetch_req = (state == rv_pkg::FS_FETCHING) && run;
	assign fetch_idx = pc;
	assign halt_word = (mem_rdata == '0);
	assign take      = fetch_gnt && !stall;

	always_ff @(posedge ip_clk or posedge ip_rst) begin
		if (ip_rst) begin
			state <= rv_pkg::FS_IDLE;
			pc    <= rv_pkg::mem_idx_t'(`RESET_PC);
		end else begin
			case (state)
				rv_pkg::FS_IDLE: begin
					if (run) state <= rv_pkg::FS_FETCHING;
				end
				rv_pkg::FS_FETCHING: begin
					if (!run) begin
						state <= rv_pkg::FS_IDLE;     // pc holds, resumes later
					end else if (take && halt_word) begin
						state <= rv_pkg::FS_HALTED;
					end else if (take) begin
						pc <= pc + 1'b1;
					end
				end
				default: state <= rv_pkg::FS_HALTED;  // stays until reset
			endcase
		end
	end

	// fetch/decode register, no grant means a bubble
	always_ff @(posedge ip_clk or posedge ip_rst) begin
		if (ip_rst) begin
			if_valid <= 1'b0;
			if_done  <= 1'b0;
		end else if (!stall) begin
			if_valid <= take && !halt_word;
			if_done  <= take && halt_word;  // one slot only
		end
	end

	always_ff @(posedge ip_clk) begin
		if (!stall) if_instr <= mem_rdata;
	end

	halt_is_final: assert property (@(posedge ip_clk) disable iff (ip_rst)
		state == rv_pkg::FS_HALTED |-> !fetch_req && !fetch_gnt && !if_valid)
		else $error("fetch resumed after halt");

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
/* shared memory arbiter */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
	input  logic             data_req,
	input  logic             host_req,
	input  logic             fetch_req,
	input  logic             data_we,
	input  logic             host_we,
	input  rv_pkg::mem_idx_t data_idx,
	input  rv_pkg::mem_idx_t host_idx,
	input  rv_pkg::mem_idx_t fetch_idx,
	input  rv_pkg::xlen_t    data_wdata,
	input  rv_pkg::xlen_t    host_wdata,
	output logic             data_gnt,
	output logic             host_gnt,
	output logic             fetch_gnt,
	output rv_pkg::mem_idx_t mem_idx,
	output logic             mem_we,
	output rv_pkg::xlen_t    mem_wdata
);

	rv_pkg::mem_owner_e owner;

	always_comb begin
		// fixed priority, data > host > fetch
		if (data_req) begin
			owner = rv_pkg::OWN_DATA;
		end else if (host_req) begin
			owner = rv_pkg::OWN_HOST;
		end else if (fetch_req) begin
			owner = rv_pkg::OWN_FETCH;
		end else begin
			owner = rv_pkg::OWN_NONE;
		end

		data_gnt  = (owner == rv_pkg::OWN_DATA);
		host_gnt  = (owner == rv_pkg::OWN_HOST);
		fetch_gnt = (owner == rv_pkg::OWN_FETCH);

		case (owner)
			rv_pkg::OWN_DATA: begin
				mem_idx   = data_idx;
				mem_we    = data_we;
				mem_wdata = data_wdata;
			end
			rv_pkg::OWN_HOST: begin
				mem_idx   = host_idx;
				mem_we    = host_we;
				mem_wdata = host_wdata;
			end
			rv_pkg::OWN_FETCH: begin
				mem_idx   = fetch_idx;
				mem_we    = 1'b0;       // fetch only reads
				mem_wdata = '0;
			end
			default: begin
				mem_idx   = '0;
				mem_we    = 1'b0;
				mem_wdata = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/mem_wb_stage.sv
/* memory and writeback stage */
`timescale 1ns/1ns
`default_nettype none

`include "rv_macros.svh"

module mem_wb_stage (
	input  logic              ip_clk,
	input  logic              ip_rst,
	input  logic              stall,
	input  rv_pkg::xlen_t     ex_result,
	input  rv_pkg::xlen_t     ex_store_data,
	input  rv_pkg::reg_addr_t ex_rd,
	input  logic              ex_reg_we,
	input  logic              ex_load,
	input  logic              ex_store,
	input  logic              ex_done,
	input  rv_pkg::xlen_t     mem_rdata,
	output logic              data_req,
	output logic              data_we,
	output rv_pkg::mem_idx_t  data_idx,
	output rv_pkg::xlen_t     data_wdata,
	output rv_pkg::xlen_t     mem_fwd_data,
	output rv_pkg::reg_addr_t wb_rd,
	output logic              wb_we,
	output rv_pkg::xlen_t     wb_data,
	output logic              halted
);

	assign data_req   = ex_load || ex_store;
	assign data_we    = ex_store;
	assign data_idx   = ex_result[`MEM_IDX_W+1:2];   // byte address to word index
	assign data_wdata = ex_store_data;

	// load data goes straight to execute, no load-use bubble
	assign mem_fwd_data = ex_load ? mem_rdata : ex_result;

	always_ff @(posedge ip_clk or posedge ip_rst) begin
		if (ip_rst) begin
			wb_we  <= 1'b0;
			halted <= 1'b0;
		end else if (!stall) begin
			wb_we <= ex_reg_we;
			if (ex_done) halted <= 1'b1;   // marker reached writeback
		end
	end

	always_ff @(posedge ip_clk) begin
		if (!stall) begin
			wb_rd   <= ex_rd;
			wb_data <= mem_fwd_data;
		end
	end

	// only bubbles follow the marker
	halted_sticky: assert property (@(posedge ip_clk) disable iff (ip_rst)
		halted |=> halted && !data_req && !wb_we)
		else $error("halted dropped or pipeline still busy after halt");

endmodule

`default_nettype wire

// File: src/reg_file.sv
/* integer register file */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  logic              ip_clk,
	input  logic              ip_rst,
	input  rv_pkg::reg_addr_t rs1_addr,
	input  rv_pkg::reg_addr_t rs2_addr,
	input  rv_pkg::reg_addr_t wb_rd,
	input  logic              wb_we,
	input  rv_pkg::xlen_t     wb_data,
	output rv_pkg::xlen_t     rs1_data,
	output rv_pkg::xlen_t     rs2_data
);

	rv_pkg::xlen_t regs [32];
	logic          wr_live;

	assign wr_live = wb_we && (wb_rd != '0);   // x0 is never written

	// same-cycle write is seen by the reader
	assign rs1_data = (wr_live && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
	assign rs2_data = (wr_live && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

	always_ff @(posedge ip_clk or posedge ip_rst) begin
		if (ip_rst) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (wr_live) begin
			regs[wb_rd] <= wb_data;
		end
	end

	x0_zero: assert property (@(posedge ip_clk) disable iff (ip_rst)
		(rs1_addr == '0 -> rs1_data == '0) && (rs2_addr == '0 -> rs2_data == '0))
		else $error("x0 read nonzero");

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
/* rv32i pipeline core top */
`timescale 1ns/1ns
`default_nettype none

module rv_core_top (
	input  logic             ip_clk,
	input  logic             ip_rst,
	input  logic             run,
	input  logic             host_valid,
	input  logic             host_we,
	input  rv_pkg::mem_idx_t host_addr,
	input  rv_pkg::xlen_t    host_wdata,
	output logic             host_ready,
	output logic             host_rsp_valid,
	output rv_pkg::xlen_t    host_rdata,
	output logic             halted
);

	logic              stall;
	logic              fetch_req, fetch_gnt, data_req, data_gnt, data_we, host_gnt;
	rv_pkg::mem_idx_t  fetch_idx, data_idx, mem_idx;
	rv_pkg::xlen_t     data_wdata, mem_wdata, mem_rdata;
	logic              mem_we;
	rv_pkg::instr_t    if_instr;
	logic              if_valid, if_done;
	rv_pkg::reg_addr_t rs1_addr, rs2_addr, id_rs1_addr, id_rs2_addr, id_rd;
	rv_pkg::xlen_t     rs1_data, rs2_data, id_a, id_b, id_imm;
	rv_pkg::alu_op_e   id_alu_op;
	logic              id_use_imm, id_reg_we, id_load, id_store, id_done;
	rv_pkg::xlen_t     ex_result, ex_store_data, mem_fwd_data, wb_data;
	rv_pkg::reg_addr_t ex_rd, wb_rd;
	logic              ex_reg_we, ex_load, ex_store, ex_done, wb_we;

	assign stall      = data_req && !data_gnt;   // guard, data never loses
	assign host_ready = host_gnt;                // low while a load/store is in mem

	fetch_unit i_fetch (
		.ip_clk, .ip_rst, .run, .stall, .fetch_gnt, .mem_rdata,
		.fetch_req, .fetch_idx, .if_instr, .if_valid, .if_done
	);

	decode_stage i_decode (
		.ip_clk, .ip_rst, .stall, .if_valid, .if_done, .if_instr, .rs1_data, .rs2_data,
		.rs1_addr, .rs2_addr, .id_rs1_addr, .id_rs2_addr, .id_rd, .id_a, .id_b, .id_imm,
		.id_alu_op, .id_use_imm, .id_reg_we, .id_load, .id_store, .id_done
	);

	reg_file i_regs (
		.ip_clk, .ip_rst, .rs1_addr, .rs2_addr, .wb_rd, .wb_we, .wb_data,
		.rs1_data, .rs2_data
	);

	execute_stage i_execute (
		.ip_clk, .ip_rst, .stall, .id_rs1_addr, .id_rs2_addr, .id_rd, .id_a, .id_b,
		.id_imm, .id_alu_op, .id_use_imm, .id_reg_we, .id_load, .id_store, .id_done,
		.mem_rd(ex_rd), .mem_reg_we(ex_reg_we), .mem_fwd_data, .wb_rd, .wb_we, .wb_data,
		.ex_result, .ex_store_data, .ex_rd, .ex_reg_we, .ex_load, .ex_store, .ex_done
	);

	mem_wb_stage i_mem_wb (
		.ip_clk, .ip_rst, .stall, .ex_result, .ex_store_data, .ex_rd, .ex_reg_we,
		.ex_load, .ex_store, .ex_done, .mem_rdata, .data_req, .data_we, .data_idx,
		.data_wdata, .mem_fwd_data, .wb_rd, .wb_we, .wb_data, .halted
	);

	mem_arbiter i_arb (
		.data_req, .host_req(host_valid), .fetch_req, .data_we, .host_we,
		.data_idx, .host_idx(host_addr), .fetch_idx, .data_wdata, .host_wdata,
		.data_gnt, .host_gnt, .fetch_gnt, .mem_idx, .mem_we, .mem_wdata
	);

	unified_mem i_mem (
		.ip_clk, .mem_idx, .mem_we, .mem_wdata, .mem_rdata
	);

	// host read answers one cycle after acceptance
	always_ff @(posedge ip_clk or posedge ip_rst) begin
		if (ip_rst) begin
			host_rsp_valid <= 1'b0;
		end else begin
			host_rsp_valid <= host_gnt && !host_we;
		end
	end

	always_ff @(posedge ip_clk) begin
		if (host_gnt && !host_we) host_rdata <= mem_rdata;
	end

	no_stall: assert property (@(posedge ip_clk) disable iff (ip_rst) !stall)
		else $error("memory stage lost the shared memory");

endmodule

`default_nettype wire

// File: src/rv_macros.svh
/* rv32i core constants */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define MEM_WORDS   256    // shared memory depth
`define MEM_IDX_W   8
`define RESET_PC    0      // word index of the first fetch

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

`endif

// File: src/rv_pkg.sv
/* rv32i core types */
`default_nettype none

`include "rv_macros.svh"

package rv_pkg;

	typedef logic [`XLEN-1:0]       xlen_t;
	typedef logic [`XLEN-1:0]       instr_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`MEM_IDX_W-1:0]  mem_idx_t;   // word index, not byte address

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B    // lui
	} alu_op_e;

	typedef enum logic [1:0] {FS_IDLE, FS_FETCHING, FS_HALTED} fetch_state_e;

	// who drives the shared memory this cycle
	typedef enum logic [1:0] {OWN_NONE, OWN_DATA, OWN_HOST, OWN_FETCH} mem_owner_e;

endpackage

`default_nettype wire

// File: src/unified_mem.sv
/* unified word memory */
`timescale 1ns/1ns
`default_nettype none

`include "rv_macros.svh"

module unified_mem (
	input  logic             ip_clk,
	input  rv_pkg::mem_idx_t mem_idx,
	input  logic             mem_we,
	input  rv_pkg::xlen_t    mem_wdata,
	output rv_pkg::xlen_t    mem_rdata
);

	rv_pkg::xlen_t mem [`MEM_WORDS];   // program and data share it

	// read is combinational, the owner sees data in the same cycle
	assign mem_rdata = mem[mem_idx];

	always_ff @(posedge ip_clk) begin
		if (mem_we) begin
			mem[mem_idx] <= mem_wdata;
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_rv_core.sv
/* rv32i core testbench */
`timescale 1ns/1ns
`default_nettype none

`include "rv_macros.svh"

module tb_rv_core;

	localparam int N_TESTS     = 23;
	localparam int PROG_MAX    = 25;
	localparam int LOAD_CYCLES = 10 + 2 * (PROG_MAX + 1 + 64);
	localparam int READ_CYCLES = 4 * 64;
	localparam int CYCLE_LIMIT = N_TESTS * (PROG_MAX * 4 + LOAD_CYCLES + READ_CYCLES) + 2000;

	logic             ip_clk = 1'b0;
	logic             ip_rst;
	logic             run;
	logic             host_valid, host_we;
	rv_pkg::mem_idx_t host_addr;
	rv_pkg::xlen_t    host_wdata;
	logic             host_ready, host_rsp_valid, halted;
	rv_pkg::xlen_t    host_rdata;

	logic [31:0] prog [$];
	logic [31:0] exp_data [64];   // expected words 128..191
	logic [31:0] got_data [64];
	logic [31:0] lfsr;
	string       test_name;
	int          errors = 0;
	int          checks = 0;
	int          test_errs = 0;
	int          tests_run = 0;
	int          cycles = 0;
	event        compare_ev, compare_done;

	rv_core_top i_dut (
		.ip_clk(ip_clk), .ip_rst(ip_rst), .run(run),
		.host_valid(host_valid), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_ready(host_ready),
		.host_rsp_valid(host_rsp_valid), .host_rdata(host_rdata), .halted(halted)
	);

	always #2 ip_clk = ~ip_clk;

	// run limit derived from test count and program size
	always @(negedge ip_clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("core never halted, run stopped after %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] next_bits(int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return v;
	endfunction

	function automatic logic [31:0] fill_word(int idx);
		return 32'h9e3779b9 * (idx + 1);
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
		int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(int imm, int rs1, logic [2:0] f3, int rd,
		logic [6:0] opc);
		return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
		logic [11:0] v;
		v = 12'(imm);
		return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], `OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_lui(int imm20, int rd);
		return {20'(imm20), 5'(rd), `OPC_LUI};
	endfunction

	// instruction set model, runs to the zero word and keeps the data region
	function automatic void run_reference();
		logic [31:0] m [256];
		logic [31:0] x [32];
		logic [31:0] w, a, b, r, imm_i, imm_s, addr;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic        wr;
		int          i, pc;
		for (i = 0; i < 256; i++) m[i] = '0;
		for (i = 0; i < 32; i++) x[i] = '0;
		for (i = 0; i < prog.size(); i++) m[i] = prog[i];
		for (i = 0; i < 64; i++) m[128 + i] = fill_word(128 + i);
		pc = 0;
		while (pc < 256 && m[pc] != '0) begin
			w     = m[pc];
			f3    = w[14:12];
			rd    = w[11:7];
			a     = x[w[19:15]];
			b     = x[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
			wr    = 1'b1;
			r     = '0;
			case (w[6:0])
				`OPC_OP: begin
					case (f3)
						3'd0: r = w[30] ? a - b : a + b;
						3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						3'd4: r = a ^ b;
						3'd6: r = a | b;
						default: r = a & b;
					endcase
				end
				`OPC_OP_IMM: begin
					case (f3)
						3'd0: r = a + imm_i;
						3'd4: r = a ^ imm_i;
						3'd6: r = a | imm_i;
						default: r = a & imm_i;
					endcase
				end
				`OPC_LUI: r = {w[31:12], 12'h000};
				`OPC_LOAD: begin
					addr = a + imm_i;
					r    = m[addr[9:2]];
				end
				default: begin   // store
					addr        = a + imm_s;
					m[addr[9:2]] = b;
					wr          = 1'b0;
				end
			endcase
			if (wr && rd != 0) x[rd] = r;
			pc++;
		end
		for (i = 0; i < 64; i++) exp_data[i] = m[128 + i];
	endfunction

	function automatic void gen_program(int n);
		int k, kind, rd, rs1, rs2;
		for (k = 0; k < n; k++) begin
			kind = next_bits(4);
			rd   = 1 + next_bits(3) % 7;
			rs1  = next_bits(3);
			rs2  = next_bits(3);
			case (kind)
				0: prog.push_back(enc_r(7'h00, rs2, rs1, 3'd0, rd));
				1: prog.push_back(enc_r(7'h20, rs2, rs1, 3'd0, rd));
				2: prog.push_back(enc_r(7'h00, rs2, rs1, 3'd7, rd));
				3: prog.push_back(enc_r(7'h00, rs2, rs1, 3'd6, rd));
				4: prog.push_back(enc_r(7'h00, rs2, rs1, 3'd4, rd));
				5: prog.push_back(enc_r(7'h00, rs2, rs1, 3'd2, rd));
				6: prog.push_back(enc_i(next_bits(12), rs1, 3'd0, rd, `OPC_OP_IMM));
				7: prog.push_back(enc_i(next_bits(12), rs1, 3'd7, rd, `OPC_OP_IMM));
				8: prog.push_back(enc_i(next_bits(12), rs1, 3'd6, rd, `OPC_OP_IMM));
				9: prog.push_back(enc_i(next_bits(12), rs1, 3'd4, rd, `OPC_OP_IMM));
				10: prog.push_back(enc_lui(next_bits(20), rd));
				11: prog.push_back(enc_i(512 + 4 * next_bits(6), 0, 3'd2, rd, `OPC_LOAD));
				default: prog.push_back(enc_s(512 + 4 * next_bits(6), rs2, 0));  // stores weighted up
			endcase
		end
	endfunction

	task automatic count_error();
		errors++;
		test_errs++;
	endtask

	task automatic check_word(input string what, input logic [31:0] exp,
		input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch %0s %0s: expected %h, actual %h", test_name, what, exp, got);
			count_error();
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %0s %0s, %0d errors", test_name, test_errs == 0 ? "ok" : "bad",
			test_errs);
	endtask

	task automatic reset_core();
		@(negedge ip_clk);
		ip_rst = 1'b1;
		run    = 1'b0;
		repeat (10) @(negedge ip_clk);
		ip_rst = 1'b0;
	endtask

	task automatic host_write(input int idx, input logic [31:0] val);
		@(negedge ip_clk);
		host_valid = 1'b1;
		host_we    = 1'b1;
		host_addr  = rv_pkg::mem_idx_t'(idx);
		host_wdata = val;
		#1;
		while (!host_ready) begin
			@(negedge ip_clk);
			#1;
		end
		@(negedge ip_clk);   // accepted on the rising edge just passed
		host_valid = 1'b0;
		host_we    = 1'b0;
	endtask

	task automatic host_read(input int idx, output logic [31:0] val);
		@(negedge ip_clk);
		host_valid = 1'b1;
		host_we    = 1'b0;
		host_addr  = rv_pkg::mem_idx_t'(idx);
		#1;
		while (!host_ready) begin
			@(negedge ip_clk);
			#1;
		end
		@(negedge ip_clk);
		host_valid = 1'b0;
		checks += 2;
		assert (host_rsp_valid) else begin
			$display("%0s: no read response after host read of word %0d", test_name, idx);
			count_error();
		end
		val = host_rdata;
		@(negedge ip_clk);
		assert (!host_rsp_valid) else begin
			$display("%0s: read response lasted more than one cycle", test_name);
			count_error();
		end
	endtask

	task automatic load_memory();
		int k;
		for (k = 0; k < prog.size(); k++) host_write(k, prog[k]);
		host_write(prog.size(), 32'h0);   // halt word
		for (k = 0; k < 64; k++) host_write(128 + k, fill_word(128 + k));
	endtask

	task automatic run_program(input bit poll_host);
		int k, idx;
		logic [31:0] val;
		reset_core();
		load_memory();
		run_reference();
		@(negedge ip_clk);
		run = 1'b1;
		k = 0;
		// host competes with fetch for the memory
		while (poll_host && !halted) begin
			idx = k % prog.size();
			host_read(idx, val);
			check_word($sformatf("program word %0d", idx), prog[idx], val);
			k++;
		end
		while (!halted) @(negedge ip_clk);
		for (k = 0; k < 64; k++) host_read(128 + k, got_data[k]);
		-> compare_ev;
		@(compare_done);
		checks++;
		assert (halted) else begin
			$display("%0s: halted dropped during readback", test_name);
			count_error();
		end
		run = 1'b0;
	endtask

	always @(compare_ev) begin
		for (int i = 0; i < 64; i++) begin
			check_word($sformatf("data word %0d", 128 + i), exp_data[i], got_data[i]);
		end
		-> compare_done;
	end

	initial begin
		logic [31:0] val, got;
		int i, t;
		ip_rst     = 1'b1;
		run        = 1'b0;
		host_valid = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		lfsr       = 32'hc044fc35;

		start_test("host_rw");
		reset_core();
		checks += 2;
		assert (!halted) else begin
			$display("%0s: halted high after reset", test_name);
			count_error();
		end
		assert (!host_rsp_valid) else begin
			$display("%0s: read response high after reset", test_name);
			count_error();
		end
		val = next_bits(32);
		host_write(200, val);
		host_write(7, ~val);
		host_read(200, got);
		check_word("word 200", val, got);
		host_read(7, got);
		check_word("word 7", ~val, got);
		end_test();

		start_test("alu_chain");
		prog.delete();
		prog.push_back(enc_lui(20'h80000, 1));                  // x1 = most negative
		prog.push_back(enc_i(5, 0, 3'd0, 2, `OPC_OP_IMM));
		prog.push_back(enc_r(7'h20, 1, 2, 3'd0, 3));            // sub, both forwarded
		prog.push_back(enc_r(7'h00, 3, 3, 3'd0, 4));
		prog.push_back(enc_r(7'h00, 2, 4, 3'd2, 5));            // slt
		prog.push_back(enc_r(7'h20, 2, 0, 3'd0, 6));            // x6 = -5
		prog.push_back(enc_r(7'h00, 5, 6, 3'd4, 7));
		prog.push_back(enc_r(7'h00, 3, 7, 3'd6, 1));
		prog.push_back(enc_r(7'h00, 6, 1, 3'd7, 2));
		prog.push_back(enc_i(-1, 2, 3'd4, 3, `OPC_OP_IMM));
		prog.push_back(enc_i(12'h123, 3, 3'd6, 4, `OPC_OP_IMM));
		prog.push_back(enc_i(12'h7f0, 4, 3'd7, 5, `OPC_OP_IMM));
		prog.push_back(enc_r(7'h00, 0, 6, 3'd2, 6));            // negative < x0
		for (i = 1; i < 8; i++) prog.push_back(enc_s(512 + 4 * i, i, 0));
		run_program(1'b0);
		end_test();

		start_test("load_use");
		prog.delete();
		prog.push_back(enc_i(-300, 0, 3'd0, 1, `OPC_OP_IMM));
		prog.push_back(enc_s(512, 1, 0));
		prog.push_back(enc_i(512, 0, 3'd2, 2, `OPC_LOAD));     // reads the word just stored
		prog.push_back(enc_r(7'h00, 2, 2, 3'd0, 3));            // uses it at once
		prog.push_back(enc_s(516, 3, 0));
		prog.push_back(enc_i(520, 0, 3'd2, 4, `OPC_LOAD));
		prog.push_back(enc_r(7'h00, 3, 4, 3'd4, 5));
		prog.push_back(enc_s(524, 5, 0));
		prog.push_back(enc_i(524, 0, 3'd2, 6, `OPC_LOAD));
		prog.push_back(enc_s(528, 6, 0));                       // store data from a load
		run_program(1'b0);
		end_test();

		for (t = 0; t < 20; t++) begin
			start_test($sformatf("random_%0d", t));
			prog.delete();
			gen_program(24);
			run_program(1'b0);
			end_test();
		end

		start_test("contention");
		prog.delete();
		gen_program(24);
		run_program(1'b1);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/rv_pkg.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/fetch_unit.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/rv_core_top.sv
tb/tb_rv_core.sv
